// ==== rnm_top.f ====
+incdir+testbench
source/rnm_pkg.sv
source/rnm_line.sv
source/rnm_segment.sv
source/rnm_arch_ctrl.sv
source/rnm_top.sv
testbench/rnm_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the rename tag array testbench with Verilator and run it
# the simulator's exit status is the result
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module rnm_tb -f rnm_top.f -o rnm_sim \
  && ./obj_dir/rnm_sim \
  || exit 1

// ==== source/rnm_arch_ctrl.sv ====
`timescale 1ns/1ns

module rnm_arch_ctrl #(
  parameter int SEG_DEPTH = 4
) (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    arch_swt_i,
  input  rnm_pkg::rename_map_t                    upper_tail_i,
  input  rnm_pkg::rename_map_t                    lower_tail_i,
  input  rnm_pkg::rn_line_t [SEG_DEPTH-1:0]       upper_rn_i,
  input  rnm_pkg::rn_line_t [SEG_DEPTH-1:0]       lower_rn_i,
  output rnm_pkg::rename_map_t                    upper_head_o,
  output rnm_pkg::rename_map_t                    lower_head_o,
  output rnm_pkg::rn_line_t [2*SEG_DEPTH-1:0]     rn_o,
  output rnm_pkg::rn_line_t [2*SEG_DEPTH-1:0]     rn_reo_o
);

  import rnm_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // arch bit
  //////////////////////////////////////////////////////////////////////

  // set while the lower segment is older
  logic arch_q;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      arch_q <= 1'b0;
    end
    else if (arch_swt_i)
    begin
      arch_q <= !arch_q;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // segment headers
  //////////////////////////////////////////////////////////////////////

  // top header heads upper while upper is older
  // mid header heads lower while lower is older
  rename_map_t top_hdr_q;
  rename_map_t mid_hdr_q;

  // on a switch the older segment retires into the other header
  logic top_hdr_en;
  logic mid_hdr_en;

  assign top_hdr_en = arch_swt_i && arch_q;
  assign mid_hdr_en = arch_swt_i && !arch_q;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      top_hdr_q <= RESET_MAP;
    end
    else if (top_hdr_en)
    begin
      // lower was older so its tail is the new committed state
      top_hdr_q <= lower_tail_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      mid_hdr_q <= RESET_MAP;
    end
    else if (mid_hdr_en)
    begin
      // upper was older so its tail is captured
      mid_hdr_q <= upper_tail_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // head selection
  //////////////////////////////////////////////////////////////////////

  // older segment reads its header
  // younger one chains off the older tail
  assign upper_head_o = arch_q ? lower_tail_i : top_hdr_q;
  assign lower_head_o = arch_q ? mid_hdr_q    : upper_tail_i;

  //////////////////////////////////////////////////////////////////////
  // output ordering
  //////////////////////////////////////////////////////////////////////

  // queue order puts upper lines at the low indices
  assign rn_o = {lower_rn_i, upper_rn_i};

  // priority order puts the older segment at the low indices
  assign rn_reo_o = arch_q ? {upper_rn_i, lower_rn_i} : {lower_rn_i, upper_rn_i};

endmodule

// ==== source/rnm_line.sv ====
`timescale 1ns/1ns

module rnm_line (
  input  logic                            clk,
  input  logic                            rst_n,
  input  rnm_pkg::isq_line_t              isq_i,
  input  rnm_pkg::rename_map_t            prv_map_i,
  input  logic                            dst_rdy_i,
  input  logic                            dst_rdy_en_i,
  output rnm_pkg::rename_map_t            cur_map_o,
  output rnm_pkg::rn_line_t               rn_o,
  output logic                            inst_rdy_o,
  output logic [rnm_pkg::PREG_BITS-1:0]   free_tag_o
);

  import rnm_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // destination ready flag
  //////////////////////////////////////////////////////////////////////

  // ready state of this line's pdest, loaded by the writeback pulse
  logic dst_rdy_q;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      dst_rdy_q <= 1'b0;
    end
    else if (dst_rdy_en_i)
    begin
      dst_rdy_q <= dst_rdy_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // source lookup
  //////////////////////////////////////////////////////////////////////

  // entries of both logical sources in the map from the line above
  map_entry_t src1_ent;
  map_entry_t src2_ent;

  assign src1_ent = prv_map_i[isq_i.lsrc1];
  assign src2_ent = prv_map_i[isq_i.lsrc2];

  // renamed line, valid bits follow the logical ones
  always_comb
  begin
    rn_o.inst_vld  = isq_i.inst_vld;
    rn_o.psrc1_vld = isq_i.lsrc1_vld;
    rn_o.psrc1_rdy = src1_ent.rdy;
    rn_o.psrc1     = src1_ent.tag;
    rn_o.psrc2_vld = isq_i.lsrc2_vld;
    rn_o.psrc2_rdy = src2_ent.rdy;
    rn_o.psrc2     = src2_ent.tag;
    // control and pdest ride along
    rn_o.ctrl      = isq_i.ctrl;
    rn_o.pdest     = isq_i.pdest;
  end

  // a source that is not used never holds the line back
  logic src1_ok;
  logic src2_ok;

  assign src1_ok    = !isq_i.lsrc1_vld || src1_ent.rdy;
  assign src2_ok    = !isq_i.lsrc2_vld || src2_ent.rdy;
  assign inst_rdy_o = isq_i.inst_vld && src1_ok && src2_ok;

  //////////////////////////////////////////////////////////////////////
  // map update
  //////////////////////////////////////////////////////////////////////

  // line writes a destination only when both valids are up
  logic       wr_dst;
  map_entry_t dst_ent;

  assign wr_dst      = isq_i.inst_vld && isq_i.ldst_vld;
  assign dst_ent.rdy = dst_rdy_q;
  assign dst_ent.tag = isq_i.pdest;

  always_comb
  begin
    // pass everything down, then overwrite ldst
    cur_map_o = prv_map_i;
    if (wr_dst)
    begin
      cur_map_o[isq_i.ldst] = dst_ent;
    end
  end

  // old mapping of ldst is released once this line retires
  assign free_tag_o = wr_dst ? prv_map_i[isq_i.ldst].tag : '0;

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  // the queue never marks operands on an empty line
  a_vld_needs_inst : assert property (
    @(posedge clk) disable iff (!rst_n)
    (isq_i.ldst_vld || isq_i.lsrc1_vld || isq_i.lsrc2_vld) |-> isq_i.inst_vld
  );

endmodule

// ==== source/rnm_pkg.sv ====
package rnm_pkg;

  //////////////////////////////////////////////////////////////////////
  // rename widths
  //////////////////////////////////////////////////////////////////////

  // logical register file size
  parameter int NUM_LREG  = 16;
  // physical tag width
  parameter int PREG_BITS = 6;
  // logical index width
  parameter int LREG_BITS = 4;
  // opaque control bits, carried through untouched
  parameter int CTRL_BITS = 8;

  //////////////////////////////////////////////////////////////////////
  // map types
  //////////////////////////////////////////////////////////////////////

  // one map entry: ready flag over physical tag
  typedef struct packed {
    logic                 rdy;
    logic [PREG_BITS-1:0] tag;
  } map_entry_t;

  // full logical to physical map, entry r sits at index r
  typedef map_entry_t [NUM_LREG-1:0] rename_map_t;

  //////////////////////////////////////////////////////////////////////
  // line types
  //////////////////////////////////////////////////////////////////////

  // issue-queue line as seen by the tag array
  typedef struct packed {
    logic                 inst_vld;
    logic                 lsrc1_vld;
    logic [LREG_BITS-1:0] lsrc1;
    logic                 lsrc2_vld;
    logic [LREG_BITS-1:0] lsrc2;
    logic                 ldst_vld;
    logic [LREG_BITS-1:0] ldst;
    logic [CTRL_BITS-1:0] ctrl;
    logic [PREG_BITS-1:0] pdest;
  } isq_line_t;

  // renamed line handed to the picker
  typedef struct packed {
    logic                 inst_vld;
    logic                 psrc1_vld;
    logic                 psrc1_rdy;
    logic [PREG_BITS-1:0] psrc1;
    logic                 psrc2_vld;
    logic                 psrc2_rdy;
    logic [PREG_BITS-1:0] psrc2;
    logic [CTRL_BITS-1:0] ctrl;
    logic [PREG_BITS-1:0] pdest;
  } rn_line_t;

  // identity map, logical r on physical r, all ready
  function automatic rename_map_t reset_map_f();
    rename_map_t m;
    for (int r = 0; r < NUM_LREG; r++)
    begin
      m[r].rdy = 1'b1;
      m[r].tag = PREG_BITS'(r);
    end
    return m;
  endfunction

  parameter rename_map_t RESET_MAP = reset_map_f();

endpackage

// ==== source/rnm_segment.sv ====
`timescale 1ns/1ns

module rnm_segment #(
  parameter int SEG_DEPTH = 4
) (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  rnm_pkg::isq_line_t [SEG_DEPTH-1:0]            isq_i,
  input  logic [SEG_DEPTH-1:0]                          dst_rdy_i,
  input  logic [SEG_DEPTH-1:0]                          dst_rdy_en_i,
  input  rnm_pkg::rename_map_t                          head_map_i,
  output rnm_pkg::rename_map_t                          tail_map_o,
  output rnm_pkg::rn_line_t [SEG_DEPTH-1:0]             rn_o,
  output logic [SEG_DEPTH-1:0]                          inst_rdy_o,
  output logic [SEG_DEPTH-1:0][rnm_pkg::PREG_BITS-1:0]  free_tag_o
);

  import rnm_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // map chain
  //////////////////////////////////////////////////////////////////////

  // map_chain[k] feeds line k, map_chain[k+1] is what line k leaves
  rename_map_t map_chain [SEG_DEPTH:0];

  // segment starts from whatever head the arch control picked
  assign map_chain[0] = head_map_i;

  // last line's view is the segment tail
  assign tail_map_o = map_chain[SEG_DEPTH];

  //////////////////////////////////////////////////////////////////////
  // lines
  //////////////////////////////////////////////////////////////////////

  genvar k;
  generate
    for (k = 0; k < SEG_DEPTH; k++)
    begin : g_line
      rnm_line u_line (
        .clk          (clk),
        .rst_n        (rst_n),
        .isq_i        (isq_i[k]),
        .prv_map_i    (map_chain[k]),
        .dst_rdy_i    (dst_rdy_i[k]),
        .dst_rdy_en_i (dst_rdy_en_i[k]),
        .cur_map_o    (map_chain[k+1]),
        .rn_o         (rn_o[k]),
        .inst_rdy_o   (inst_rdy_o[k]),
        .free_tag_o   (free_tag_o[k])
      );
    end
  endgenerate

endmodule

// ==== source/rnm_top.sv ====
`timescale 1ns/1ns

module rnm_top #(
  parameter int DEPTH = 8
) (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  rnm_pkg::isq_line_t [DEPTH-1:0]            isq_lines_i,
  input  logic [DEPTH-1:0]                          dst_rdy_i,
  input  logic [DEPTH-1:0]                          dst_rdy_en_i,
  input  logic                                      arch_swt_i,
  output rnm_pkg::rn_line_t [DEPTH-1:0]             rn_lines_o,
  output rnm_pkg::rn_line_t [DEPTH-1:0]             rn_lines_reo_o,
  output logic [DEPTH-1:0]                          inst_rdy_o,
  output logic [DEPTH-1:0][rnm_pkg::PREG_BITS-1:0]  free_tag_o
);

  import rnm_pkg::*;

  // each segment covers half of the queue
  localparam int SEG_DEPTH = DEPTH / 2;

  generate
    if (DEPTH % 2 != 0)
    begin : g_depth_chk
      $error("rnm_top: DEPTH must be even");
    end
  endgenerate

  //////////////////////////////////////////////////////////////////////
  // segment interconnect
  //////////////////////////////////////////////////////////////////////

  rename_map_t                  upper_head;
  rename_map_t                  lower_head;
  rename_map_t                  upper_tail;
  rename_map_t                  lower_tail;
  rn_line_t [SEG_DEPTH-1:0]     upper_rn;
  rn_line_t [SEG_DEPTH-1:0]     lower_rn;

  // upper half, lines 0 .. SEG_DEPTH-1
  rnm_segment #(.SEG_DEPTH(SEG_DEPTH)) seg_upper (
    .clk          (clk),
    .rst_n        (rst_n),
    .isq_i        (isq_lines_i[SEG_DEPTH-1:0]),
    .dst_rdy_i    (dst_rdy_i[SEG_DEPTH-1:0]),
    .dst_rdy_en_i (dst_rdy_en_i[SEG_DEPTH-1:0]),
    .head_map_i   (upper_head),
    .tail_map_o   (upper_tail),
    .rn_o         (upper_rn),
    .inst_rdy_o   (inst_rdy_o[SEG_DEPTH-1:0]),
    .free_tag_o   (free_tag_o[SEG_DEPTH-1:0])
  );

  // lower half, lines SEG_DEPTH .. DEPTH-1
  rnm_segment #(.SEG_DEPTH(SEG_DEPTH)) seg_lower (
    .clk          (clk),
    .rst_n        (rst_n),
    .isq_i        (isq_lines_i[DEPTH-1:SEG_DEPTH]),
    .dst_rdy_i    (dst_rdy_i[DEPTH-1:SEG_DEPTH]),
    .dst_rdy_en_i (dst_rdy_en_i[DEPTH-1:SEG_DEPTH]),
    .head_map_i   (lower_head),
    .tail_map_o   (lower_tail),
    .rn_o         (lower_rn),
    .inst_rdy_o   (inst_rdy_o[DEPTH-1:SEG_DEPTH]),
    .free_tag_o   (free_tag_o[DEPTH-1:SEG_DEPTH])
  );

  // headers, head muxing and output ordering
  rnm_arch_ctrl #(.SEG_DEPTH(SEG_DEPTH)) arch_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .arch_swt_i   (arch_swt_i),
    .upper_tail_i (upper_tail),
    .lower_tail_i (lower_tail),
    .upper_rn_i   (upper_rn),
    .lower_rn_i   (lower_rn),
    .upper_head_o (upper_head),
    .lower_head_o (lower_head),
    .rn_o         (rn_lines_o),
    .rn_reo_o     (rn_lines_reo_o)
  );

endmodule

// ==== testbench/rnm_tb_util.svh ====
`ifndef RNM_TB_UTIL_SVH
`define RNM_TB_UTIL_SVH

//////////////////////////////////////////////////////////////////////
// random numbers
//////////////////////////////////////////////////////////////////////

// fibonacci lfsr, taps 32 22 2 1, one step per bit handed out
function automatic logic [63:0] take_bits(inout logic [31:0] st, input int n);
  logic [63:0] val;
  logic        fb;
  val = '0;
  for (int i = 0; i < n; i++)
  begin
    fb  = st[31] ^ st[21] ^ st[1] ^ st[0];
    st  = {st[30:0], fb};
    val = {val[62:0], fb};
  end
  return val;
endfunction

//////////////////////////////////////////////////////////////////////
// reference rename model
//////////////////////////////////////////////////////////////////////

// walk every line, older segment first, carrying one map down the chain
function automatic void walk_chain(
  input  isq_line_t [DEPTH-1:0]            lines,
  input  logic [DEPTH-1:0]                 rdy,
  input  logic                             arch,
  input  rename_map_t                      top_hdr,
  input  rename_map_t                      mid_hdr,
  output rn_line_t [DEPTH-1:0]             rn,
  output rn_line_t [DEPTH-1:0]             reo,
  output logic [DEPTH-1:0]                 irdy,
  output logic [DEPTH-1:0][PREG_BITS-1:0]  ftag,
  output rename_map_t                      up_tail,
  output rename_map_t                      lo_tail
);
  rename_map_t map;
  isq_line_t   ln;
  map_entry_t  s1;
  map_entry_t  s2;
  int          k;
  // older segment starts from its own header
  map = arch ? mid_hdr : top_hdr;
  for (int n = 0; n < DEPTH; n++)
  begin
    k  = arch ? (n + HALF) % DEPTH : n;
    ln = lines[k];
    s1 = map[ln.lsrc1];
    s2 = map[ln.lsrc2];
    rn[k] = '{ln.inst_vld, ln.lsrc1_vld, s1.rdy, s1.tag,
              ln.lsrc2_vld, s2.rdy, s2.tag, ln.ctrl, ln.pdest};
    // unused sources count as ready
    irdy[k] = ln.inst_vld && (s1.rdy || !ln.lsrc1_vld) && (s2.rdy || !ln.lsrc2_vld);
    ftag[k] = '0;
    // a written destination frees the old mapping
    if (ln.inst_vld && ln.ldst_vld)
    begin
      ftag[k]      = map[ln.ldst].tag;
      map[ln.ldst] = '{rdy[k], ln.pdest};
    end
    if (k == HALF - 1)
    begin
      up_tail = map;
    end
    if (k == DEPTH - 1)
    begin
      lo_tail = map;
    end
    // walk order is the priority order
    reo[n] = rn[k];
  end
endfunction

`endif

// ==== testbench/rnm_tb.sv ====
`timescale 1ns/1ns

module rnm_tb;

  import rnm_pkg::*;

  localparam int DEPTH     = 8;
  localparam int HALF      = DEPTH / 2;
  localparam int PERIOD    = 40;
  localparam int LINE_BITS = $bits(isq_line_t);
  localparam int RAND_CYC  = 200;
  // reset and directed phases take 20 cycles
  localparam int RUN_CYC   = 20 + RAND_CYC;
  localparam int MARGIN    = 100;

  `include "rnm_tb_util.svh"

  logic                            clk;
  logic                            rst_n;
  isq_line_t [DEPTH-1:0]           isq_lines;
  logic [DEPTH-1:0]                dst_rdy;
  logic [DEPTH-1:0]                dst_rdy_en;
  logic                            arch_swt;
  rn_line_t [DEPTH-1:0]            rn_lines;
  rn_line_t [DEPTH-1:0]            rn_lines_reo;
  logic [DEPTH-1:0]                inst_rdy;
  logic [DEPTH-1:0][PREG_BITS-1:0] free_tag;
  logic [31:0]                     lfsr_st;

  // mirrored dut state
  logic                            m_arch;
  rename_map_t                     m_top_hdr;
  rename_map_t                     m_mid_hdr;
  logic [DEPTH-1:0]                m_rdy;

  // expected values from the model
  rn_line_t [DEPTH-1:0]            exp_rn;
  rn_line_t [DEPTH-1:0]            exp_reo;
  logic [DEPTH-1:0]                exp_irdy;
  logic [DEPTH-1:0][PREG_BITS-1:0] exp_ftag;
  rename_map_t                     exp_up_tail;
  rename_map_t                     exp_lo_tail;

  rnm_top #(.DEPTH(DEPTH)) rnm_top_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .isq_lines_i    (isq_lines),
    .dst_rdy_i      (dst_rdy),
    .dst_rdy_en_i   (dst_rdy_en),
    .arch_swt_i     (arch_swt),
    .rn_lines_o     (rn_lines),
    .rn_lines_reo_o (rn_lines_reo),
    .inst_rdy_o     (inst_rdy),
    .free_tag_o     (free_tag)
  );

  always #(PERIOD / 2) clk = !clk;

  //////////////////////////////////////////////////////////////////////
  // state mirror and model
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      m_arch    <= 1'b0;
      m_top_hdr <= RESET_MAP;
      m_mid_hdr <= RESET_MAP;
      m_rdy     <= '0;
    end
    else
    begin
      m_rdy <= (m_rdy & ~dst_rdy_en) | (dst_rdy & dst_rdy_en);
      if (arch_swt)
      begin
        m_arch <= !m_arch;
        // older segment's tail becomes the other header
        if (m_arch)
        begin
          m_top_hdr <= exp_lo_tail;
        end
        else
        begin
          m_mid_hdr <= exp_up_tail;
        end
      end
    end
  end

  always_comb
  begin
    walk_chain(isq_lines, m_rdy, m_arch, m_top_hdr, m_mid_hdr,
               exp_rn, exp_reo, exp_irdy, exp_ftag, exp_up_tail, exp_lo_tail);
  end

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string what);
    $display("ERR %0t %s does not match the model", $time, what);
    $display("=== FAIL ===");
    $fatal(1, "output mismatch");
  endtask

  chk_rn : assert property (@(posedge clk) disable iff (!rst_n) rn_lines == exp_rn)
    else report_mismatch("rn_lines_o");
  chk_reo : assert property (@(posedge clk) disable iff (!rst_n) rn_lines_reo == exp_reo)
    else report_mismatch("rn_lines_reo_o");
  chk_irdy : assert property (@(posedge clk) disable iff (!rst_n) inst_rdy == exp_irdy)
    else report_mismatch("inst_rdy_o");
  chk_ftag : assert property (@(posedge clk) disable iff (!rst_n) free_tag == exp_ftag)
    else report_mismatch("free_tag_o");

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  // inputs change 5 ns after the edge
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #5;
  endtask

  initial
  begin
    #((RUN_CYC + MARGIN) * PERIOD);
    $display("simulation timed out before all phases finished");
    $display("=== FAIL ===");
    $fatal(1, "watchdog expired");
  end

  initial
  begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    isq_lines  = '0;
    dst_rdy    = '0;
    dst_rdy_en = '0;
    arch_swt   = 1'b0;
    lfsr_st    = 32'h5577_7e95;
    wait_cycles(4);
    rst_n = 1'b1;
    // empty lines still look up r and r+8 in the reset map
    for (int k = 0; k < DEPTH; k++)
    begin
      isq_lines[k].lsrc1 = LREG_BITS'(k);
      isq_lines[k].lsrc2 = LREG_BITS'(k + 8);
    end
    wait_cycles(2);
    // line 1 maps r3 to p40, lines 2 and 6 read it
    isq_lines[1] = '{1'b1, 1'b1, 4'd2, 1'b0, 4'd0, 1'b1, 4'd3, 8'h11, 6'd40};
    isq_lines[2] = '{1'b1, 1'b1, 4'd3, 1'b1, 4'd5, 1'b1, 4'd7, 8'h22, 6'd41};
    isq_lines[6] = '{1'b1, 1'b1, 4'd3, 1'b1, 4'd7, 1'b0, 4'd0, 8'h66, 6'd42};
    wait_cycles(2);
    // writeback of p40 then p41
    dst_rdy    = 8'b0000_0110;
    dst_rdy_en = 8'b0000_0010;
    wait_cycles(1);
    dst_rdy_en = 8'b0000_0100;
    wait_cycles(1);
    dst_rdy_en = '0;
    wait_cycles(2);
    // lower goes first, then the order comes back
    repeat (2)
    begin
      arch_swt = 1'b1;
      wait_cycles(1);
      arch_swt = 1'b0;
      wait_cycles(3);
    end
    // random lines, ready pulses and switches
    for (int c = 0; c < RAND_CYC; c++)
    begin
      for (int k = 0; k < DEPTH; k++)
      begin
        isq_lines[k] = LINE_BITS'(take_bits(lfsr_st, LINE_BITS));
        // operand valids only on a valid line
        if (!isq_lines[k].inst_vld)
        begin
          isq_lines[k].lsrc1_vld = 1'b0;
          isq_lines[k].lsrc2_vld = 1'b0;
          isq_lines[k].ldst_vld  = 1'b0;
        end
      end
      dst_rdy    = DEPTH'(take_bits(lfsr_st, DEPTH));
      dst_rdy_en = DEPTH'(take_bits(lfsr_st, DEPTH));
      // about one switch in eight cycles
      arch_swt   = (take_bits(lfsr_st, 3) == 64'd0);
      wait_cycles(1);
    end
    $display("=== PASS ===");
    $finish;
  end

endmodule
